/* source/cn_pkg.sv */
`default_nettype none

package cn_pkg;

    // bus and word widths
    localparam int BUS_DW = 16;               // wishbone data width
    localparam int BUS_AW = 8;                // wishbone address width
    localparam int WORD_W = 32;               // parameter and result width

    // one 32 bit word seen whole or as two bus halves
    typedef union packed {
        logic [WORD_W-1:0] raw;               // parameter view
        struct packed {
            logic [BUS_DW-1:0] hi;            // upper bus half
            logic [BUS_DW-1:0] lo;            // lower bus half
        } halves;
    } cn_word_u;

    // write side of the map
    localparam logic [BUS_AW-1:0] ADDR_STAGE_LO = 8'h01;   // staging bits 15..0
    localparam logic [BUS_AW-1:0] ADDR_STAGE_HI = 8'h02;   // staging bits 31..16
    localparam logic [BUS_AW-1:0] ADDR_TRIG     = 8'h50;   // commit mask

    // read side of the map
    localparam logic [BUS_AW-1:0] ADDR_COUNT_LO = 8'h24;
    localparam logic [BUS_AW-1:0] ADDR_COUNT_HI = 8'h25;
    localparam logic [BUS_AW-1:0] ADDR_DRIVE_LO = 8'h26;
    localparam logic [BUS_AW-1:0] ADDR_DRIVE_HI = 8'h27;
    localparam logic [BUS_AW-1:0] ADDR_EXTRA_LO = 8'h28;
    localparam logic [BUS_AW-1:0] ADDR_EXTRA_HI = 8'h29;
    localparam logic [BUS_AW-1:0] ADDR_SCALER   = 8'h2C;

    // bit positions inside the commit word
    localparam int TRIG_SYN_GAIN = 3;
    localparam int TRIG_EXTRA    = 8;

    localparam logic [WORD_W-1:0] SYN_GAIN_RST = 32'd1;    // unity gain
    localparam logic [WORD_W-1:0] EXTRA_RST    = 32'd0;    // no cortical drive

    localparam int TH_MV    = 30;             // firing threshold in mV
    localparam int TH_SHIFT = 10;             // fixed point scaling of the threshold

endpackage

`default_nettype wire

/* source/reg_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_decode (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire                        i_wb_cyc,
    input  wire                        i_wb_stb,
    input  wire                        i_wb_we,
    input  wire [cn_pkg::BUS_AW-1:0]   i_wb_adr,
    input  wire [cn_pkg::BUS_DW-1:0]   i_wb_dat,
    input  wire [cn_pkg::WORD_W-1:0]   i_drive,        // latched drive for readback
    input  wire [3:0]                  i_scaler,       // button gain
    input  wire [cn_pkg::WORD_W-1:0]   i_spike_count,
    output logic [cn_pkg::BUS_DW-1:0]  o_wb_dat,
    output logic                       o_wb_ack,
    output logic [cn_pkg::WORD_W-1:0]  o_syn_gain,
    output logic [cn_pkg::WORD_W-1:0]  o_extra_drive
);

    import cn_pkg::*;

    logic               wb_req;        // new request, ack not yet given
    logic               wb_wr;         // request is a write
    cn_word_u           stage_q;       // staging word built from two halves
    cn_word_u           drive_w;
    cn_word_u           count_w;
    cn_word_u           extra_w;
    logic [BUS_DW-1:0]  rd_mux;

    assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // ack only from low
    assign wb_wr  = wb_req & i_wb_we;

    // results split into bus halves
    always_comb begin
        drive_w.raw = i_drive;
        count_w.raw = i_spike_count;
        extra_w.raw = o_extra_drive;
    end

    // fixed single cycle acknowledge
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req;
        end
    end

    // staging halves and the commit of parameters
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            stage_q.raw   <= '0;
            o_syn_gain    <= SYN_GAIN_RST;
            o_extra_drive <= EXTRA_RST;
        end else if (wb_wr) begin
            case (i_wb_adr)
                ADDR_STAGE_LO: stage_q.halves.lo <= i_wb_dat;
                ADDR_STAGE_HI: stage_q.halves.hi <= i_wb_dat;
                ADDR_TRIG: begin
                    // every set bit picks up the whole staged word
                    if (i_wb_dat[TRIG_SYN_GAIN]) begin
                        o_syn_gain <= stage_q.raw;
                    end
                    if (i_wb_dat[TRIG_EXTRA]) begin
                        o_extra_drive <= stage_q.raw;
                    end
                end
                default: ;                     // read only or unmapped
            endcase
        end
    end

    // readback select
    always_comb begin
        case (i_wb_adr)
            ADDR_COUNT_LO: rd_mux = count_w.halves.lo;
            ADDR_COUNT_HI: rd_mux = count_w.halves.hi;
            ADDR_DRIVE_LO: rd_mux = drive_w.halves.lo;
            ADDR_DRIVE_HI: rd_mux = drive_w.halves.hi;
            ADDR_EXTRA_LO: rd_mux = extra_w.halves.lo;
            ADDR_EXTRA_HI: rd_mux = extra_w.halves.hi;
            ADDR_SCALER:   rd_mux = {{(BUS_DW-4){1'b0}}, i_scaler};   // zero stuffed
            default:       rd_mux = '0;
        endcase
    end

    // read data captured on the same edge that raises ack
    always_ff @(posedge ep50trig) begin
        if (wb_req && !i_wb_we) begin
            o_wb_dat <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* source/drive_execute.sv */
`default_nettype none
`timescale 1ns/1ps

module drive_execute #(
    parameter int SPINDLE_SHIFT = 9,           // fixed point weight of the spindle term
    parameter int SCALER_MAX    = 5            // scaler wraps to 1 after this
) (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire                        i_tick,          // one step of simulated time
    input  wire                        i_spike_ia,
    input  wire                        i_spike_ii,
    input  wire                        i_button,        // asynchronous push button
    input  wire [cn_pkg::WORD_W-1:0]   i_syn_gain,
    input  wire [cn_pkg::WORD_W-1:0]   i_extra_drive,
    output logic [cn_pkg::WORD_W-1:0]  o_drive,
    output logic                       o_drive_valid,
    output logic [3:0]                 o_scaler
);

    import cn_pkg::*;

    logic               btn_s1;        // first sync stage
    logic               btn_s2;        // second sync stage
    logic               btn_chg;
    logic [1:0]         spk_cnt;       // Ia plus II this tick
    logic [WORD_W-1:0]  spindle_term;
    logic [WORD_W-1:0]  cortical_term;
    logic [WORD_W-1:0]  drive_sum;

    // button synchroniser
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_s1 <= 1'b0;
            btn_s2 <= 1'b0;
        end else begin
            btn_s1 <= i_button;
            btn_s2 <= btn_s1;
        end
    end

    assign btn_chg = btn_s1 ^ btn_s2;          // either edge counts

    // gain scaler 1..SCALER_MAX
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_scaler <= 4'd1;
        end else if (btn_chg) begin
            if (o_scaler == 4'(SCALER_MAX)) begin
                o_scaler <= 4'd1;              // wrap around
            end else begin
                o_scaler <= o_scaler + 4'd1;
            end
        end
    end

    assign spk_cnt       = {1'b0, i_spike_ia} + {1'b0, i_spike_ii};
    assign spindle_term  = (WORD_W'(spk_cnt) * i_syn_gain) << SPINDLE_SHIFT;
    assign cortical_term = i_extra_drive * WORD_W'(o_scaler);   // button scaled cortex
    // shift applies to the spindle term alone
    assign drive_sum     = spindle_term + cortical_term;

    // drive latch once per tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_drive       <= '0;
            o_drive_valid <= 1'b0;
        end else begin
            o_drive_valid <= i_tick;           // neuron sees the new drive next cycle
            if (i_tick) begin
                o_drive <= drive_sum;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cn_result.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_result (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire [cn_pkg::WORD_W-1:0]   i_drive,         // latched drive
    input  wire                        i_drive_valid,   // integrate this cycle
    output logic                       o_spike,
    output logic [cn_pkg::WORD_W-1:0]  o_spike_count
);

    import cn_pkg::*;

    // 30 mV in the same fixed point as the drive
    localparam logic [WORD_W:0] TH_VAL = (WORD_W+1)'(TH_MV) << TH_SHIFT;

    logic [WORD_W:0]  pot_q;           // membrane potential with one guard bit
    logic [WORD_W:0]  pot_sum;
    logic             fire;

    assign pot_sum = pot_q + {1'b0, i_drive};
    assign fire    = (pot_sum >= TH_VAL);

    // integrate and subtract on threshold crossing
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            pot_q         <= '0;
            o_spike       <= 1'b0;
            o_spike_count <= '0;
        end else begin
            o_spike <= i_drive_valid & fire;   // single cycle pulse
            if (i_drive_valid) begin
                if (fire) begin
                    pot_q         <= pot_sum - TH_VAL;   // threshold taken once
                    o_spike_count <= o_spike_count + 1'b1;
                end else begin
                    pot_q <= pot_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/cn_drive_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_drive_top #(
    parameter int SPINDLE_SHIFT = 9,
    parameter int SCALER_MAX    = 5
) (
    input  wire                        ep50trig,        // system clock
    input  wire                        reset_global,
    input  wire                        i_wb_cyc,
    input  wire                        i_wb_stb,
    input  wire                        i_wb_we,
    input  wire [cn_pkg::BUS_AW-1:0]   i_wb_adr,
    input  wire [cn_pkg::BUS_DW-1:0]   i_wb_dat,
    output wire [cn_pkg::BUS_DW-1:0]   o_wb_dat,
    output wire                        o_wb_ack,
    input  wire                        i_tick,
    input  wire                        i_spike_ia,      // spindle Ia afferent
    input  wire                        i_spike_ii,      // spindle II afferent
    input  wire                        i_button,
    output wire                        o_spike
);

    import cn_pkg::*;

    wire [WORD_W-1:0]  syn_gain;
    wire [WORD_W-1:0]  extra_drive;
    wire [WORD_W-1:0]  drive;
    wire               drive_valid;
    wire [3:0]         scaler;
    wire [WORD_W-1:0]  spike_count;

    // bus slave and parameter store
    reg_decode reg_decode_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_drive       (drive),
        .i_scaler      (scaler),
        .i_spike_count (spike_count),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_syn_gain    (syn_gain),
        .o_extra_drive (extra_drive)
    );

    drive_execute #(
        .SPINDLE_SHIFT (SPINDLE_SHIFT),
        .SCALER_MAX    (SCALER_MAX)
    ) drive_execute_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_tick        (i_tick),
        .i_spike_ia    (i_spike_ia),
        .i_spike_ii    (i_spike_ii),
        .i_button      (i_button),
        .i_syn_gain    (syn_gain),
        .i_extra_drive (extra_drive),
        .o_drive       (drive),
        .o_drive_valid (drive_valid),
        .o_scaler      (scaler)
    );

    // cuneate neuron
    cn_result cn_result_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_drive       (drive),
        .i_drive_valid (drive_valid),
        .o_spike       (o_spike),
        .o_spike_count (spike_count)
    );

endmodule

`default_nettype wire

/* bench/cn_model.svh */
`ifndef CN_MODEL_SVH
`define CN_MODEL_SVH

// reference state of the node updated in bus and tick order
logic [31:0] m_stage;                    // staged parameter word
logic [31:0] m_gain;
logic [31:0] m_extra;
logic [3:0]  m_scaler;
logic [31:0] m_drive;
logic [32:0] m_pot;                      // unsigned 33 bit potential
logic [31:0] m_count;

task automatic reset_model_state();
    m_stage  = 32'd0;
    m_gain   = 32'd1;
    m_extra  = 32'd0;
    m_scaler = 4'd1;
    m_drive  = 32'd0;
    m_pot    = 33'd0;
    m_count  = 32'd0;
endtask

task automatic record_write(input logic [7:0] adr, input logic [15:0] dat);
    case (adr)
        ADDR_STAGE_LO: m_stage[15:0]  = dat;
        ADDR_STAGE_HI: m_stage[31:16] = dat;
        ADDR_TRIG: begin
            if (dat[TRIG_SYN_GAIN]) begin
                m_gain = m_stage;
            end
            if (dat[TRIG_EXTRA]) begin
                m_extra = m_stage;
            end
        end
        default: ;                       // read only and unmapped writes do nothing
    endcase
endtask

function automatic logic [15:0] readback_value(input logic [7:0] adr);
    case (adr)
        ADDR_COUNT_LO: return m_count[15:0];
        ADDR_COUNT_HI: return m_count[31:16];
        ADDR_DRIVE_LO: return m_drive[15:0];
        ADDR_DRIVE_HI: return m_drive[31:16];
        ADDR_EXTRA_LO: return m_extra[15:0];
        ADDR_EXTRA_HI: return m_extra[31:16];
        ADDR_SCALER:   return {12'd0, m_scaler};
        default:       return 16'd0;
    endcase
endfunction

// one level change of the button
task automatic advance_scaler();
    m_scaler = (m_scaler == 4'(SCALER_MAX)) ? 4'd1 : m_scaler + 4'd1;
endtask

// latch the drive and integrate it and fire reports a threshold crossing
task automatic predict_tick(input logic ia, input logic ii, output logic fire);
    logic [32:0] next_pot;
    logic [32:0] th;
    th       = 33'(TH_MV) << TH_SHIFT;
    m_drive  = (((32'(ia) + 32'(ii)) * m_gain) << SPINDLE_SHIFT) + m_extra * 32'(m_scaler);
    next_pot = m_pot + {1'b0, m_drive};
    fire     = (next_pot >= th);
    m_pot    = fire ? next_pot - th : next_pot;
    m_count  = fire ? m_count + 32'd1 : m_count;
endtask

`endif

/* bench/cn_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module cn_tb;

    import cn_pkg::*;

    localparam int SPINDLE_SHIFT = 9;
    localparam int SCALER_MAX    = 5;
    localparam int PLANNED_OPS   = 600;                    // bus, button and tick steps
    localparam int CYCLE_LIMIT   = 4 * PLANNED_OPS * 6;    // up to 6 cycles per step

    logic               ep50trig;
    logic               reset_global;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [BUS_AW-1:0]  wb_adr;
    logic [BUS_DW-1:0]  wb_dat_w;
    wire  [BUS_DW-1:0]  wb_dat_r;
    wire                wb_ack;
    logic               tick;
    logic               spike_ia;
    logic               spike_ii;
    logic               button;
    wire                spike;
    int                 cycle_cnt = 0;

    `include "cn_model.svh"

    cn_drive_top #(
        .SPINDLE_SHIFT (SPINDLE_SHIFT),
        .SCALER_MAX    (SCALER_MAX)
    ) cn_drive_top_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_wb_cyc     (wb_cyc),
        .i_wb_stb     (wb_stb),
        .i_wb_we      (wb_we),
        .i_wb_adr     (wb_adr),
        .i_wb_dat     (wb_dat_w),
        .o_wb_dat     (wb_dat_r),
        .o_wb_ack     (wb_ack),
        .i_tick       (tick),
        .i_spike_ia   (spike_ia),
        .i_spike_ii   (spike_ii),
        .i_button     (button),
        .o_spike      (spike)
    );

    initial begin
        ep50trig = 1'b0;
        forever #4 ep50trig = ~ep50trig;     // 8 ns period
    end

    always @(posedge ep50trig) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run took more than %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        reset_global = 1'b1;
        tick         = 1'b0;
        button       = 1'b0;                 // sync stages restart from a low level
        repeat (10) @(negedge ep50trig);
        reset_global = 1'b0;
        reset_model_state();
    endtask

    // one classic cycle started and ended on a falling edge
    task automatic wb_access(input logic we, input logic [BUS_AW-1:0] adr,
                             input logic [BUS_DW-1:0] dat, output logic [BUS_DW-1:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge ep50trig);
        while (!wb_ack) begin
            @(negedge ep50trig);
        end
        rdata  = wb_dat_r;                   // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] dat);
        logic [BUS_DW-1:0] unused_rd;
        wb_access(1'b1, adr, dat, unused_rd);
        record_write(adr, dat);
    endtask

    task automatic expect_read(input logic [BUS_AW-1:0] adr, input string what);
        logic [BUS_DW-1:0] data;
        wb_access(1'b0, adr, 16'd0, data);
        check_value(32'(data), 32'(readback_value(adr)), what);
    endtask

    task automatic load_params(input logic [31:0] gain, input logic [31:0] extra);
        write_reg(ADDR_STAGE_LO, gain[15:0]);
        write_reg(ADDR_STAGE_HI, gain[31:16]);
        write_reg(ADDR_TRIG, 16'(1 << TRIG_SYN_GAIN));
        write_reg(ADDR_STAGE_LO, extra[15:0]);
        write_reg(ADDR_STAGE_HI, extra[31:16]);
        write_reg(ADDR_TRIG, 16'(1 << TRIG_EXTRA));
    endtask

    task automatic toggle_button();
        button = ~button;
        advance_scaler();
        repeat (3 + $urandom % 3) @(negedge ep50trig);   // held past the synchroniser
    endtask

    // tick with random afferents and then watch the spike window
    task automatic step_tick();
        logic fire;
        tick     = 1'b1;
        spike_ia = 1'($urandom);
        spike_ii = 1'($urandom);
        predict_tick(spike_ia, spike_ii, fire);
        @(negedge ep50trig);
        tick = 1'b0;
        check_value(32'(spike), 32'd0, "spike one cycle after tick");
        @(negedge ep50trig);
        check_value(32'(spike), 32'(fire), "spike two cycles after tick");
        @(negedge ep50trig);
        check_value(32'(spike), 32'd0, "spike three cycles after tick");
    endtask

    initial begin
        void'($urandom(73445));
        reset_global = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        tick         = 1'b0;
        spike_ia     = 1'b0;
        spike_ii     = 1'b0;
        button       = 1'b0;
        apply_reset();

        // reset values
        check_value(32'(wb_ack), 32'd0, "ack before any request");
        expect_read(ADDR_SCALER, "scaler after reset");
        expect_read(ADDR_DRIVE_LO, "drive low after reset");
        expect_read(ADDR_DRIVE_HI, "drive high after reset");
        expect_read(ADDR_COUNT_LO, "count low after reset");
        expect_read(ADDR_COUNT_HI, "count high after reset");
        expect_read(ADDR_EXTRA_LO, "extra low after reset");
        expect_read(ADDR_EXTRA_HI, "extra high after reset");

        // staged loads with random commit masks
        repeat (30) begin
            write_reg(ADDR_STAGE_LO, 16'($urandom));
            write_reg(ADDR_STAGE_HI, 16'($urandom));
            write_reg(ADDR_TRIG, 16'($urandom));
            write_reg(ADDR_DRIVE_LO, 16'($urandom));    // ignored by the read only map
            expect_read(ADDR_EXTRA_LO, "extra drive low");
            expect_read(ADDR_EXTRA_HI, "extra drive high");
            expect_read(8'h60 + 8'($urandom % 160), "unmapped read");
        end

        repeat (30) begin
            toggle_button();
            expect_read(ADDR_SCALER, "scaler step");
        end

        // full width parameters so the drive sum wraps
        for (int i = 0; i < 40; i++) begin
            if (i % 10 == 0) begin
                load_params($urandom, $urandom);
            end
            if ($urandom % 4 == 0) begin
                toggle_button();
            end
            step_tick();
            expect_read(ADDR_DRIVE_LO, "drive low");
            expect_read(ADDR_DRIVE_HI, "drive high");
        end

        // fresh potential and a drive kept near the threshold
        apply_reset();
        repeat (8) begin
            load_params($urandom % 48, $urandom % 6000);
            repeat (5 + $urandom % 11) begin
                step_tick();
                repeat ($urandom % 3) @(negedge ep50trig);   // idle gap
            end
            expect_read(ADDR_COUNT_LO, "spike count low");
            expect_read(ADDR_COUNT_HI, "spike count high");
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
source/cn_pkg.sv
source/reg_decode.sv
source/drive_execute.sv
source/cn_result.sv
source/cn_drive_top.sv
bench/cn_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = cn_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
